// ==== sources.f ====
source/fftPkg.sv
source/sampleFramer.sv
source/sdfStage.sv
source/twiddleRotator.sv
source/bitReverseBuffer.sv
source/fftStream.sv
test/fftStream_props.sv
test/fftStreamTb.sv

// ==== Bender.yml ====
package:
  name: fft_stream

sources:
  - files:
      - source/fftPkg.sv
      - source/sampleFramer.sv
      - source/sdfStage.sv
      - source/twiddleRotator.sv
      - source/bitReverseBuffer.sv
      - source/fftStream.sv
  - target: test
    files:
      - test/fftStream_props.sv
      - test/fftStreamTb.sv

// ==== test/fftStreamTb.sv ====
`timescale 1ns/1ps

module fftStreamTb
	import fftPkg::*;
();

	localparam int SENT_FRAMES    = 8;         // Four test frames each followed by a flush
	localparam int CHECKED_FRAMES = 7;         // Last flush never gets pushed out
	localparam int WAIT_LIMIT     = 400;
	localparam int PEAK           = 1600;

	typedef enum int {ZERO_FILL, IMPULSE_FILL, CONSTANT_FILL, TONE_FILL} fillKind;

	logic    CLK;
	logic    RST;
	complexT sampleIn;
	logic    sampleValid;
	complexT binOut;
	logic    binValid;
	logic    frameStart;
	complexT frameBuf [FFT_POINTS];            // Frame about to be sent
	complexT gotBins [SENT_FRAMES][FFT_POINTS];
	real     expRe [SENT_FRAMES][FFT_POINTS];  // DFT / 16 of each sent frame
	real     expIm [SENT_FRAMES][FFT_POINTS];
	int      tolerance [SENT_FRAMES];
	string   frameName [SENT_FRAMES];
	int      framesSent = 0;
	int      framesGot = 0;
	int      binIdx = FFT_POINTS;              // Ignores bins until the first frame start
	int      errors = 0;
	int      checks = 0;
	int      propFails;
	logic [15:0] lfsrState;

	always #20 CLK = ~CLK;

	fftStream uut (
		.CLK           (CLK),
		.RST           (RST),
		.sampleIn_i    (sampleIn),
		.sampleValid_i (sampleValid),
		.binOut_o      (binOut),
		.binValid_o    (binValid),
		.frameStart_o  (frameStart)
	);

	// Collector samples away from the active edge
	always @(negedge CLK)
	begin
		if (binValid && frameStart)
		begin
			binIdx = 0;
		end
		if (binValid && (binIdx < FFT_POINTS) && (framesGot < SENT_FRAMES))
		begin
			gotBins[framesGot][binIdx] = binOut;
			binIdx++;
			if (binIdx == FFT_POINTS)
			begin
				framesGot++;
			end
		end
	end

	// Galois LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic bit withinTol(input logic signed [DATA_WIDTH-1:0] got, input real expVal,
		input int tol);
		real d;
		d = got - expVal;
		return (d <= tol) && (d >= -tol);
	endfunction

	task automatic fillFrame(input fillKind kind);
		for (int n = 0; n < FFT_POINTS; n++)
		begin
			frameBuf[n] = '0;
			case (kind)
				IMPULSE_FILL:  frameBuf[n].re = (n == 0) ? DATA_WIDTH'(PEAK) : '0;
				CONSTANT_FILL: frameBuf[n].re = DATA_WIDTH'(PEAK);
				TONE_FILL:                       // PEAK * conj(W16^n) puts a tone on bin 1
				begin
					frameBuf[n].re = DATA_WIDTH'(int'(PEAK * TWIDDLE_RE[POS_WIDTH'(n)] / 16384.0));
					frameBuf[n].im = DATA_WIDTH'(int'(-PEAK * TWIDDLE_IM[POS_WIDTH'(n)] / 16384.0));
				end
				default: ;
			endcase
		end
	endtask

	// Direct DFT from the coefficient table scaled by 1/16
	task automatic storeReference(input string name, input int tol);
		real wr;
		real wi;
		real accRe;
		real accIm;
		for (int k = 0; k < FFT_POINTS; k++)
		begin
			accRe = 0.0;
			accIm = 0.0;
			for (int n = 0; n < FFT_POINTS; n++)
			begin
				wr = TWIDDLE_RE[POS_WIDTH'(n * k)] / 16384.0;
				wi = TWIDDLE_IM[POS_WIDTH'(n * k)] / 16384.0;
				accRe += frameBuf[n].re * wr - frameBuf[n].im * wi;
				accIm += frameBuf[n].re * wi + frameBuf[n].im * wr;
			end
			expRe[framesSent][k] = accRe / FFT_POINTS;
			expIm[framesSent][k] = accIm / FFT_POINTS;
		end
		frameName[framesSent] = name;
		tolerance[framesSent] = tol;
	endtask

	task automatic sendFrame(input string name, input int tol, input bit gapped);
		bit gapBit;
		storeReference(name, tol);
		for (int n = 0; n < FFT_POINTS; n++)
		begin
			gapBit    = lfsrState[0];           // One bit per possible idle cycle
			lfsrState = gapped ? lfsrStep(lfsrState) : lfsrState;
			if (gapped && gapBit)
			begin
				@(posedge CLK);
				sampleValid <= 1'b0;
			end
			@(posedge CLK);
			sampleIn    <= frameBuf[n];
			sampleValid <= 1'b1;
		end
		framesSent++;
	endtask

	task automatic waitFrames();
		int cycles;
		cycles = 0;
		while ((framesGot < CHECKED_FRAMES) && (cycles < WAIT_LIMIT))
		begin
			@(posedge CLK);
			cycles++;
		end
		if (framesGot < CHECKED_FRAMES)
		begin
			errors++;
			$display("Timeout: only %0d of %0d output frames arrived", framesGot, CHECKED_FRAMES);
		end
	endtask

	task automatic checkFrame(input int f);
		for (int k = 0; k < FFT_POINTS; k++)
		begin
			checks++;
			assert (withinTol(gotBins[f][k].re, expRe[f][k], tolerance[f]) &&
				withinTol(gotBins[f][k].im, expIm[f][k], tolerance[f]))
			else
			begin
				errors++;
				$display("[FAIL] %s bin %0d: expected (%0.2f, %0.2f), actual (%0d, %0d)",
					frameName[f], k, expRe[f][k], expIm[f][k], gotBins[f][k].re, gotBins[f][k].im);
			end
		end
	endtask

	initial
	begin
		CLK         = 1'b0;
		RST         = 1'b1;
		sampleIn    = '0;
		sampleValid = 1'b0;
		lfsrState   = 16'd48;
		repeat (10) @(posedge CLK);
		RST <= 1'b0;
		@(posedge CLK);
		fillFrame(IMPULSE_FILL);
		sendFrame("impulse", 2, 1'b0);
		fillFrame(ZERO_FILL);
		sendFrame("flush", 2, 1'b0);
		fillFrame(CONSTANT_FILL);
		sendFrame("constant", 2, 1'b0);
		fillFrame(ZERO_FILL);
		sendFrame("flush", 2, 1'b0);
		fillFrame(TONE_FILL);
		sendFrame("tone", 3, 1'b0);
		fillFrame(ZERO_FILL);
		sendFrame("flush", 2, 1'b0);
		fillFrame(CONSTANT_FILL);                // Phase 3 again with valid gaps
		sendFrame("gapped", 2, 1'b1);
		fillFrame(ZERO_FILL);
		sendFrame("flush", 2, 1'b1);
		@(posedge CLK);
		sampleValid <= 1'b0;
		waitFrames();
		for (int f = 0; f < framesGot && f < CHECKED_FRAMES; f++)
		begin
			checkFrame(f);
		end
		for (int k = 0; k < FFT_POINTS && framesGot >= CHECKED_FRAMES; k++)
		begin
			checks++;
			assert (gotBins[6][k] == gotBins[2][k])  // Gaps must not change any bit
			else
			begin
				errors++;
				$display("[FAIL] gapped bin %0d: expected %h, actual %h", k, gotBins[2][k],
					gotBins[6][k]);
			end
		end
		propFails = uut.props.totalFails;
		$display("Checks: %0d, check errors: %0d, property failures: %0d", checks, errors,
			propFails);
		if ((errors == 0) && (propFails == 0))
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== test/fftStream_props.sv ====
`timescale 1ns/1ps

module fftStream_props
	import fftPkg::*;
(
	input logic CLK,
	input logic RST,
	input logic sampleValid_i,
	input logic binValid_i,
	input logic frameStart_i
);

	logic [POS_WIDTH:0] inputCount;             // Valid inputs since reset, saturating
	int                 quietFails = 0;
	int                 lengthFails = 0;
	int                 orphanFails = 0;
	int                 totalFails;

	assign totalFails = quietFails + lengthFails + orphanFails;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			inputCount <= '0;
		end
		else if (sampleValid_i && (inputCount < (POS_WIDTH+1)'(FFT_POINTS)))
		begin
			inputCount <= inputCount + 1'b1;
		end
	end

	// Output stays silent until a whole frame could have entered
	assert property (@(posedge CLK)
		(RST || (inputCount < (POS_WIDTH+1)'(FFT_POINTS))) |-> (!binValid_i && !frameStart_i))
	else
	begin
		quietFails++;
		$error("Output active during reset or before a full frame entered");
	end

	// Bin 0 plus 15 further bins back to back
	assert property (@(posedge CLK) disable iff (RST) frameStart_i |-> binValid_i [*16])
	else
	begin
		lengthFails++;
		$error("Output frame shorter than 16 consecutive bins");
	end

	assert property (@(posedge CLK) disable iff (RST) $rose(binValid_i) |-> frameStart_i)
	else
	begin
		orphanFails++;
		$error("Bin stream started without a frame start");
	end

endmodule

bind fftStream fftStream_props props (
	.CLK           (CLK),
	.RST           (RST),
	.sampleValid_i (sampleValid_i),
	.binValid_i    (binValid_o),
	.frameStart_i  (frameStart_o)
);

// ==== source/fftStream.sv ====
`timescale 1ns/1ps

module fftStream
	import fftPkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  complexT sampleIn_i,
	input  logic    sampleValid_i,
	output complexT binOut_o,
	output logic    binValid_o,
	output logic    frameStart_o
);

	sampleT framed;                             // Tagged input stream
	sampleT stage1Out;
	sampleT stage2Out;
	sampleT rotated;                            // After the W16 multiply
	sampleT stage3Out;
	sampleT stage4Out;                          // Bit-reversed bins

	sampleFramer framer (
		.CLK           (CLK),
		.RST           (RST),
		.sampleIn_i    (sampleIn_i),
		.sampleValid_i (sampleValid_i),
		.sample_o      (framed)
	);

	// First radix-2^2 pair over the 16-point span
	sdfStage #(.DELAY(8), .ROTATE_NEG_J(1'b1)) stage1 (
		.CLK (CLK), .RST (RST), .sample_i (framed), .sample_o (stage1Out)
	);

	sdfStage #(.DELAY(4), .ROTATE_NEG_J(1'b0)) stage2 (
		.CLK (CLK), .RST (RST), .sample_i (stage1Out), .sample_o (stage2Out)
	);

	twiddleRotator rotator (
		.CLK (CLK), .RST (RST), .sample_i (stage2Out), .sample_o (rotated)
	);

	// Second pair finishes the four-point sub-transforms
	sdfStage #(.DELAY(2), .ROTATE_NEG_J(1'b1)) stage3 (
		.CLK (CLK), .RST (RST), .sample_i (rotated), .sample_o (stage3Out)
	);

	sdfStage #(.DELAY(1), .ROTATE_NEG_J(1'b0)) stage4 (
		.CLK (CLK), .RST (RST), .sample_i (stage3Out), .sample_o (stage4Out)
	);

	bitReverseBuffer reorder (
		.CLK          (CLK),
		.RST          (RST),
		.sample_i     (stage4Out),
		.binOut_o     (binOut_o),
		.binValid_o   (binValid_o),
		.frameStart_o (frameStart_o)
	);

endmodule

// ==== source/bitReverseBuffer.sv ====
`timescale 1ns/1ps

module bitReverseBuffer
	import fftPkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  sampleT  sample_i,
	output complexT binOut_o,
	output logic    binValid_o,
	output logic    frameStart_o
);

	complexT              bankMem [2*FFT_POINTS];   // Two frames, bank bit on top
	logic                 writeBank;                // Bank being filled
	logic                 readBank;                 // Bank being emptied
	logic                 aligned;                  // A frame start has been seen
	logic                 reading;
	logic [POS_WIDTH-1:0] readAddr;                 // Natural bin index
	logic [POS_WIDTH-1:0] writeAddr;
	logic                 writeEn;
	logic                 frameDone;

	function automatic logic [POS_WIDTH-1:0] bitRev(input logic [POS_WIDTH-1:0] p);
		logic [POS_WIDTH-1:0] r;
		for (int i = 0; i < POS_WIDTH; i++)
		begin
			r[i] = p[POS_WIDTH-1-i];
		end
		return r;
	endfunction

	// Slots before the first position 0 are pipeline fill and get dropped
	assign writeEn   = sample_i.valid && (aligned || (sample_i.pos == '0));
	assign writeAddr = bitRev(sample_i.pos);                   // Slot q holds bin bitrev(q)
	assign frameDone = writeEn && (&sample_i.pos);             // Last slot of the frame

	always_ff @(posedge CLK)
	begin
		if (writeEn)
		begin
			bankMem[{writeBank, writeAddr}] <= sample_i.data;
		end
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			aligned   <= 1'b0;
			writeBank <= 1'b0;
			readBank  <= 1'b0;
			reading   <= 1'b0;
			readAddr  <= '0;
		end
		else
		begin
			if (writeEn)
			begin
				aligned <= 1'b1;
			end
			if (frameDone)
			begin
				writeBank <= ~writeBank;        // Next frame goes to the other bank
				readBank  <= writeBank;         // Full bank drains in natural order
				reading   <= 1'b1;
				readAddr  <= '0;
			end
			else if (reading)
			begin
				readAddr <= readAddr + 1'b1;
				if (&readAddr)
				begin
					reading <= 1'b0;            // Sixteen bins out
				end
			end
		end
	end

	assign binOut_o     = bankMem[{readBank, readAddr}];
	assign binValid_o   = reading;
	assign frameStart_o = reading && (readAddr == '0);         // Flags bin 0

endmodule

// ==== source/twiddleRotator.sv ====
`timescale 1ns/1ps

module twiddleRotator
	import fftPkg::*;
(
	input  logic   CLK,
	input  logic   RST,
	input  sampleT sample_i,
	output sampleT sample_o
);

	localparam int FRAC_BITS = COEF_WIDTH - 2;                 // Q1.14 fraction
	localparam int PROD_WIDTH = DATA_WIDTH + COEF_WIDTH;
	localparam int ACC_WIDTH  = PROD_WIDTH + 1;

	logic [1:0]                    quarterRev;                 // Bit-reversed quarter index
	logic [POS_WIDTH-1:0]          exponent;                   // Power of W16
	logic signed [COEF_WIDTH-1:0]  coefRe;
	logic signed [COEF_WIDTH-1:0]  coefIm;
	logic signed [PROD_WIDTH-1:0]  prodRr;
	logic signed [PROD_WIDTH-1:0]  prodIi;
	logic signed [PROD_WIDTH-1:0]  prodRi;
	logic signed [PROD_WIDTH-1:0]  prodIr;
	logic signed [ACC_WIDTH-1:0]   accRe;
	logic signed [ACC_WIDTH-1:0]   accIm;
	complexT                       rotated;
	logic                          validQ;
	logic [POS_WIDTH-1:0]          posQ;
	complexT                       dataQ;

	// Drop the fraction toward minus infinity and clip to the data range
	function automatic logic signed [DATA_WIDTH-1:0] scaleSat(input logic signed [ACC_WIDTH-1:0] v);
		logic signed [ACC_WIDTH-1:0] shifted;
		shifted = v >>> FRAC_BITS;
		if (&shifted[ACC_WIDTH-1:DATA_WIDTH-1] || ~|shifted[ACC_WIDTH-1:DATA_WIDTH-1])
		begin
			return shifted[DATA_WIDTH-1:0];
		end
		else if (shifted[ACC_WIDTH-1])
		begin
			return {1'b1, {(DATA_WIDTH-1){1'b0}}};   // Negative overflow
		end
		return {1'b0, {(DATA_WIDTH-1){1'b1}}};       // Positive overflow
	endfunction

	// Quarters 0..3 use 0, 2n, n and 3n
	assign quarterRev = {sample_i.pos[POS_WIDTH-2], sample_i.pos[POS_WIDTH-1]};
	assign exponent   = {2'b00, sample_i.pos[1:0]} * {2'b00, quarterRev};
	assign coefRe     = TWIDDLE_RE[exponent];
	assign coefIm     = TWIDDLE_IM[exponent];

	// (a + jb)(c + jd) with four multipliers
	assign prodRr  = $signed(sample_i.data.re) * coefRe;
	assign prodIi  = $signed(sample_i.data.im) * coefIm;
	assign prodRi  = $signed(sample_i.data.re) * coefIm;
	assign prodIr  = $signed(sample_i.data.im) * coefRe;
	assign accRe   = prodRr - prodIi;
	assign accIm   = prodRi + prodIr;
	assign rotated = '{re: scaleSat(accRe), im: scaleSat(accIm)};

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			validQ <= 1'b0;
		end
		else
		begin
			validQ <= sample_i.valid;           // Single cycle through the multiplier
		end
	end

	always_ff @(posedge CLK)
	begin
		if (sample_i.valid)
		begin
			posQ  <= sample_i.pos;              // Rotation keeps the slot
			dataQ <= rotated;
		end
	end

	assign sample_o = '{valid: validQ, pos: posQ, data: dataQ};

endmodule

// ==== source/sdfStage.sv ====
`timescale 1ns/1ps

module sdfStage
	import fftPkg::*;
#(
	parameter int DELAY        = 1,             // Feedback depth, also the butterfly distance
	parameter bit ROTATE_NEG_J = 1'b0           // Trivial -j rotation on the last quarter
)(
	input  logic   CLK,
	input  logic   RST,
	input  sampleT sample_i,
	output sampleT sample_o
);

	localparam int STAGE_BIT = $clog2(DELAY);   // Position bit that selects the butterfly phase
	localparam int SPAN      = 2 * DELAY;       // Positions covered by one butterfly group

	complexT                     delayLine [DELAY];
	complexT                     head;          // Oldest entry of the feedback line
	complexT                     sum;
	complexT                     diff;
	complexT                     feedback;      // Value pushed into the line
	complexT                     emitted;       // Value leaving the stage
	logic signed [DATA_WIDTH:0]  sumRe;
	logic signed [DATA_WIDTH:0]  sumIm;
	logic signed [DATA_WIDTH:0]  diffRe;
	logic signed [DATA_WIDTH:0]  diffIm;
	logic [POS_WIDTH-1:0]        outPos;
	logic                        butterflyPhase;
	logic                        lastQuarter;
	logic                        validQ;
	logic [POS_WIDTH-1:0]        posQ;
	complexT                     dataQ;

	// Negation clipped at the positive limit
	function automatic logic signed [DATA_WIDTH-1:0] negSat(input logic signed [DATA_WIDTH-1:0] x);
		if (x == {1'b1, {(DATA_WIDTH-1){1'b0}}})
		begin
			return {1'b0, {(DATA_WIDTH-1){1'b1}}};
		end
		return -x;
	endfunction

	assign head           = delayLine[DELAY-1];
	assign butterflyPhase = sample_i.pos[STAGE_BIT];               // Second half of the group
	assign outPos         = sample_i.pos - POS_WIDTH'(DELAY);      // Slot the emitted value belongs to
	assign lastQuarter    = (outPos & POS_WIDTH'(SPAN - 1)) >= POS_WIDTH'((3 * SPAN) / 4);

	// Halving butterfly, floor of the half keeps the result in range
	assign sumRe  = $signed(head.re) + $signed(sample_i.data.re);
	assign sumIm  = $signed(head.im) + $signed(sample_i.data.im);
	assign diffRe = $signed(head.re) - $signed(sample_i.data.re);
	assign diffIm = $signed(head.im) - $signed(sample_i.data.im);
	assign sum    = '{re: sumRe[DATA_WIDTH:1], im: sumIm[DATA_WIDTH:1]};
	assign diff   = '{re: diffRe[DATA_WIDTH:1], im: diffIm[DATA_WIDTH:1]};

	always_comb
	begin
		if (butterflyPhase)
		begin
			emitted  = sum;                     // Sum leaves now
			feedback = diff;                    // Difference waits DELAY samples
		end
		else
		begin
			feedback = sample_i.data;           // Fill with the first half of the group
			if (ROTATE_NEG_J && lastQuarter)
			begin
				emitted.re = head.im;           // Multiply by -j
				emitted.im = negSat(head.re);
			end
			else
			begin
				emitted = head;                 // Pending difference from the last group
			end
		end
	end

	// Feedback line shifts on valid samples only
	always_ff @(posedge CLK)
	begin
		if (sample_i.valid)
		begin
			delayLine[0] <= feedback;
			for (int i = 1; i < DELAY; i++)
			begin
				delayLine[i] <= delayLine[i-1];
			end
		end
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			validQ <= 1'b0;
		end
		else
		begin
			validQ <= sample_i.valid;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (sample_i.valid)
		begin
			posQ  <= outPos;
			dataQ <= emitted;
		end
	end

	assign sample_o = '{valid: validQ, pos: posQ, data: dataQ};

endmodule

// ==== source/sampleFramer.sv ====
`timescale 1ns/1ps

module sampleFramer
	import fftPkg::*;
(
	input  logic    CLK,
	input  logic    RST,
	input  complexT sampleIn_i,
	input  logic    sampleValid_i,
	output sampleT  sample_o
);

	logic [POS_WIDTH-1:0] posCount;             // Position given to the next valid input
	logic                 validQ;
	logic [POS_WIDTH-1:0] posQ;
	complexT              dataQ;

	// Frame position wraps every FFT_POINTS valid samples
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			posCount <= '0;
			validQ   <= 1'b0;
		end
		else
		begin
			validQ <= sampleValid_i;            // One cycle of input latency
			if (sampleValid_i)
			begin
				posCount <= posCount + 1'b1;    // Advances on valid only
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (sampleValid_i)
		begin
			posQ  <= posCount;                  // Tag travels with the sample
			dataQ <= sampleIn_i;
		end
	end

	assign sample_o = '{valid: validQ, pos: posQ, data: dataQ};

endmodule

// ==== source/fftPkg.sv ====
package fftPkg;

	localparam int FFT_POINTS = 16;             // Transform size
	localparam int POS_WIDTH  = 4;              // Frame position tag width
	localparam int DATA_WIDTH = 16;             // Signed real or imaginary part
	localparam int COEF_WIDTH = 16;             // Signed Q1.14 twiddle part

	// One complex sample word
	typedef struct packed {
		logic signed [DATA_WIDTH-1:0] re;       // Real part
		logic signed [DATA_WIDTH-1:0] im;       // Imaginary part
	} complexT;

	// Complex payload as it travels between stages
	typedef struct packed {
		logic                 valid;            // Sample qualifier
		logic [POS_WIDTH-1:0] pos;              // Position inside the frame
		complexT              data;             // Payload
	} sampleT;

	// cos(2*pi*k/16) scaled by 2^14
	localparam logic signed [COEF_WIDTH-1:0] TWIDDLE_RE [FFT_POINTS] = '{
		16'sd16384,  16'sd15137,  16'sd11585,  16'sd6270,
		16'sd0,     -16'sd6270,  -16'sd11585, -16'sd15137,
		-16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270,
		16'sd0,      16'sd6270,   16'sd11585,  16'sd15137
	};

	// -sin(2*pi*k/16) scaled by 2^14
	localparam logic signed [COEF_WIDTH-1:0] TWIDDLE_IM [FFT_POINTS] = '{
		16'sd0,     -16'sd6270,  -16'sd11585, -16'sd15137,
		-16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270,
		16'sd0,      16'sd6270,   16'sd11585,  16'sd15137,
		16'sd16384,  16'sd15137,  16'sd11585,  16'sd6270
	};

endpackage
